/* source/sram_pkg.sv */
`default_nettype none

package sram_pkg;

	// ************************************************************
	// Bus widths
	// ************************************************************

	typedef logic [31:0] addr_t; // Byte address on the bus.
	typedef logic [31:0] data_t; // One bus word.
	typedef logic [3:0] strb_t;  // One enable bit per data byte.

	// ************************************************************
	// Responses
	// ************************************************************

	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t resp_okay = 2'b00;   // Transfer completed.
	localparam axi_resp_t resp_slverr = 2'b10; // Address not backed by storage.

endpackage

`default_nettype wire

/* source/lfsr_random.sv */
`timescale 1ns/1ps
`default_nettype none

module lfsr_random (
	input  logic       clock,
	input  logic       reset,
	output logic [7:0] random
);

	localparam logic [15:0] seed = 16'hace1;
	// x^16 + x^14 + x^13 + x^11 + 1, maximal length.
	localparam logic [15:0] taps = 16'hb400;

	logic [15:0] state;

	// ************************************************************
	// Galois shift register, one step per cycle
	// ************************************************************

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= seed;
		end else begin
			state <= {1'b0, state[15:1]} ^ (state[0] ? taps : 16'h0000); // Feed back bit 0.
		end
	end

	assign random = state[7:0]; // Low byte feeds the delays.

	// A zero state would freeze the generator for good.
	state_never_zero: assert property (
		@(posedge clock) disable iff (reset) state != 16'h0000
	) else $error("LFSR state reached zero.");

endmodule

`default_nettype wire

/* source/response_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module response_delay #(
	parameter int delay_bits = 3
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  request,
	input  logic [delay_bits-1:0] wait_cycles,
	output logic                  valid
);

	logic                  started;   // Request was already high last cycle.
	logic [delay_bits-1:0] count;     // Cycles still to wait.
	logic [delay_bits-1:0] remaining;

	// In the first cycle of a request the wait comes straight from the input,
	// so a zero wait gives valid in the same cycle as the request.
	assign remaining = started ? count : wait_cycles;

	assign valid = request & (remaining == '0);

	// ************************************************************
	// Down-counter
	// ************************************************************

	always_ff @(posedge clock) begin
		if (reset) begin
			started <= 1'b0;
			count <= '0;
		end else begin
			started <= request;
			if (request && remaining != '0) begin
				count <= remaining - 1'b1; // Keep counting.
			end else begin
				count <= '0;               // Done, or idle.
			end
		end
	end

	// ************************************************************
	// Checks
	// ************************************************************

	// Once raised, valid only drops together with its request.
	valid_held: assert property (
		@(posedge clock) disable iff (reset) valid |=> valid || !request
	) else $error("valid dropped while the request was still high.");

endmodule

`default_nettype wire

/* source/sram_array.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_array #(
	parameter int mem_words = 1024
) (
	input  logic                         clock,
	input  logic [$clog2(mem_words)-1:0] read_index,
	output sram_pkg::data_t              read_word,
	input  logic                         write_enable,
	input  logic [$clog2(mem_words)-1:0] write_index,
	input  sram_pkg::data_t              write_word,
	input  sram_pkg::strb_t              write_strobe
);

	import sram_pkg::*;

	localparam int lanes = $bits(strb_t);
	localparam int lane_bits = $bits(data_t) / lanes; // Bits per strobe lane.

	data_t storage [mem_words];

	// ************************************************************
	// Read port
	// ************************************************************

	// Non-blocking update, so a same-index write shows up one cycle later.
	always_ff @(posedge clock) begin
		read_word <= storage[read_index];
	end

	// ************************************************************
	// Write port
	// ************************************************************

	always_ff @(posedge clock) begin
		for (int lane = 0; lane < lanes; lane++) begin
			if (write_enable && write_strobe[lane]) begin
				storage[write_index][lane*lane_bits +: lane_bits] <=
					write_word[lane*lane_bits +: lane_bits]; // Enabled bytes only.
			end
		end
	end

endmodule

`default_nettype wire

/* source/axi_lite_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_sram #(
	parameter int mem_words = 1024,
	parameter int delay_bits = 3
) (
	input  logic                clock,
	input  logic                reset,

	input  sram_pkg::addr_t     araddr,
	input  logic                arvalid,
	output logic                arready,

	output sram_pkg::data_t     rdata,
	output sram_pkg::axi_resp_t rresp,
	output logic                rvalid,
	input  logic                rready,

	input  sram_pkg::addr_t     awaddr,
	input  logic                awvalid,
	output logic                awready,

	input  sram_pkg::data_t     wdata,
	input  sram_pkg::strb_t     wstrb,
	input  logic                wvalid,
	output logic                wready,

	output sram_pkg::axi_resp_t bresp,
	output logic                bvalid,
	input  logic                bready,

	input  logic [7:0]          random
);

	import sram_pkg::*;

	localparam int index_bits = $clog2(mem_words);

	function automatic logic addr_in_range(input addr_t addr);
		return addr[$bits(addr_t)-1:2] < mem_words; // Low two bits ignored.
	endfunction

	logic ar_fire;
	logic r_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;

	assign ar_fire = arvalid & arready;
	assign r_fire = rvalid & rready;
	assign aw_fire = awvalid & awready;
	assign w_fire = wvalid & wready;
	assign b_fire = bvalid & bready;

	// ************************************************************
	// Read channel
	// ************************************************************

	addr_t araddr_q;
	logic  read_error;   // Captured range result.
	logic  read_issue;   // Array read happens at the next edge.
	logic  read_fresh;   // read_word holds the new array output.
	logic  read_pending; // Request level for the read delay.
	data_t read_word;
	data_t read_data;
	data_t rdata_hold;

	always_ff @(posedge clock) begin
		if (reset) begin
			arready <= 1'b1;
			read_issue <= 1'b0;
			read_fresh <= 1'b0;
			read_pending <= 1'b0;
		end else begin
			read_issue <= ar_fire;
			read_fresh <= read_issue;
			if (ar_fire) begin
				arready <= 1'b0;      // One read at a time.
			end else if (r_fire) begin
				arready <= 1'b1;
			end
			if (read_issue) begin
				read_pending <= 1'b1;
			end else if (r_fire) begin
				read_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			araddr_q <= araddr;
			read_error <= !addr_in_range(araddr);
		end
		rdata_hold <= read_data; // Freezes the word against later writes.
	end

	assign read_data = read_fresh ? read_word : rdata_hold;
	assign rdata = read_error ? '0 : read_data;
	assign rresp = read_error ? resp_slverr : resp_okay;

	// ************************************************************
	// Write channels
	// ************************************************************

	addr_t awaddr_q;
	logic  aw_error;      // Captured range result, also drives bresp.
	data_t wdata_q;
	strb_t wstrb_q;
	logic  aw_held;
	logic  w_held;
	logic  commit;        // Array write at the next edge.
	logic  write_pending; // Request level for the write delay.

	assign commit = aw_held & w_held;

	always_ff @(posedge clock) begin
		if (reset) begin
			awready <= 1'b1;
			wready <= 1'b1;
			aw_held <= 1'b0;
			w_held <= 1'b0;
			write_pending <= 1'b0;
		end else begin
			if (aw_fire) begin
				awready <= 1'b0;
			end else if (b_fire) begin
				awready <= 1'b1;
			end
			if (w_fire) begin
				wready <= 1'b0;
			end else if (b_fire) begin
				wready <= 1'b1;
			end
			if (aw_fire) begin
				aw_held <= 1'b1;
			end else if (commit) begin
				aw_held <= 1'b0;      // Single-cycle commit.
			end
			if (w_fire) begin
				w_held <= 1'b1;
			end else if (commit) begin
				w_held <= 1'b0;
			end
			if (commit) begin
				write_pending <= 1'b1;
			end else if (b_fire) begin
				write_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire) begin
			awaddr_q <= awaddr;
			aw_error <= !addr_in_range(awaddr);
		end
		if (w_fire) begin
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
	end

	assign bresp = aw_error ? resp_slverr : resp_okay;

	// ************************************************************
	// Storage and response delays
	// ************************************************************

	sram_array #(
		.mem_words(mem_words)
	) storage (
		.clock(clock),
		.read_index(araddr_q[index_bits+1:2]),
		.read_word(read_word),
		.write_enable(commit & ~aw_error), // Out-of-range writes are dropped.
		.write_index(awaddr_q[index_bits+1:2]),
		.write_word(wdata_q),
		.write_strobe(wstrb_q)
	);

	logic [delay_bits-1:0] read_wait;
	logic [delay_bits-1:0] write_wait;

	// Fields from opposite ends of the byte stay independent up to 4 bits.
	if (delay_bits == 0) begin : g_fixed_wait
		assign read_wait = '0;
		assign write_wait = '0;
	end else begin : g_random_wait
		assign read_wait = random[delay_bits-1:0];
		assign write_wait = random[7 -: delay_bits];
	end

	response_delay #(
		.delay_bits(delay_bits)
	) read_delay (
		.clock(clock),
		.reset(reset),
		.request(read_pending),
		.wait_cycles(read_wait),
		.valid(rvalid)
	);

	response_delay #(
		.delay_bits(delay_bits)
	) write_delay (
		.clock(clock),
		.reset(reset),
		.request(write_pending),
		.wait_cycles(write_wait),
		.valid(bvalid)
	);

	// ************************************************************
	// Checks
	// ************************************************************

	rvalid_held: assert property (
		@(posedge clock) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
	) else $error("R channel changed before its transfer.");

	bvalid_held: assert property (
		@(posedge clock) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp)
	) else $error("B channel changed before its transfer.");

	arready_blocked: assert property (
		@(posedge clock) disable iff (reset) read_pending |-> !arready
	) else $error("arready high with a read outstanding.");

endmodule

`default_nettype wire

/* source/sram_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_subsystem #(
	parameter int mem_words = 1024,
	parameter int delay_bits = 3
) (
	input  logic                clock,
	input  logic                reset,

	input  sram_pkg::addr_t     araddr,
	input  logic                arvalid,
	output logic                arready,

	output sram_pkg::data_t     rdata,
	output sram_pkg::axi_resp_t rresp,
	output logic                rvalid,
	input  logic                rready,

	input  sram_pkg::addr_t     awaddr,
	input  logic                awvalid,
	output logic                awready,

	input  sram_pkg::data_t     wdata,
	input  sram_pkg::strb_t     wstrb,
	input  logic                wvalid,
	output logic                wready,

	output sram_pkg::axi_resp_t bresp,
	output logic                bvalid,
	input  logic                bready
);

	logic [7:0] random; // Fresh random byte every cycle.

	lfsr_random random_source (
		.clock(clock),
		.reset(reset),
		.random(random)
	);

	axi_lite_sram #(
		.mem_words(mem_words),
		.delay_bits(delay_bits)
	) sram_slave (
		.clock(clock),
		.reset(reset),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.random(random)
	);

endmodule

`default_nettype wire

/* sim/tb_sram_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sram_subsystem;

	import sram_pkg::*;

	localparam int mem_words = 64;
	localparam int delay_bits = 3;
	localparam int max_wait = 1 << delay_bits; // Longest response wait in cycles.
	localparam int wait_limit = 100;           // Cycles before a handshake wait gives up.

	logic      clock;
	logic      reset;
	addr_t     araddr;
	logic      arvalid;
	logic      arready;
	data_t     rdata;
	axi_resp_t rresp;
	logic      rvalid;
	logic      rready;
	addr_t     awaddr;
	logic      awvalid;
	logic      awready;
	data_t     wdata;
	strb_t     wstrb;
	logic      wvalid;
	logic      wready;
	axi_resp_t bresp;
	logic      bvalid;
	logic      bready;

	data_t     model_mem [mem_words]; // Reference copy of the array.
	data_t     expected_rdata;
	axi_resp_t expected_rresp;
	axi_resp_t expected_bresp;
	integer    seed = 32'h7498_08cb;
	logic      read_outstanding;
	logic      aw_taken;
	logic      w_taken;
	int        read_age;              // Edges since the AR transfer.
	int        write_age;             // Edges since both AW and W were taken.

	sram_subsystem #(
		.mem_words(mem_words),
		.delay_bits(delay_bits)
	) DUT (.*);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	// ************************************************************
	// Transfer tracking
	// ************************************************************

	always @(posedge clock) begin
		if (reset) begin
			read_outstanding <= 1'b0;
			aw_taken <= 1'b0;
			w_taken <= 1'b0;
			read_age <= 0;
			write_age <= 0;
		end else begin
			read_outstanding <= (arvalid && arready) || (read_outstanding && !(rvalid && rready));
			read_age <= (arvalid && arready) ? 0 : read_age + 1;
			aw_taken <= (awvalid && awready) || (aw_taken && !(bvalid && bready));
			w_taken <= (wvalid && wready) || (w_taken && !(bvalid && bready));
			write_age <= (aw_taken && w_taken && !(bvalid && bready)) ? write_age + 1 : 0;
		end
	end

	// ************************************************************
	// Checks
	// ************************************************************

	after_reset: assert property (
		@(posedge clock) $fell(reset) |-> arready && awready && wready && !rvalid && !bvalid
	) else report_mismatch("ready and valid levels wrong after reset");

	read_response: assert property (
		@(posedge clock) disable iff (reset)
		rvalid |-> read_outstanding && rdata == expected_rdata && rresp == expected_rresp
	) else report_mismatch($sformatf("read gave %h resp %0d, expected %h resp %0d",
		$sampled(rdata), $sampled(rresp), expected_rdata, expected_rresp));

	write_response: assert property (
		@(posedge clock) disable iff (reset)
		bvalid |-> aw_taken && w_taken && bresp == expected_bresp
	) else report_mismatch($sformatf("write response %0d, expected %0d",
		$sampled(bresp), expected_bresp));

	r_stalled: assert property (
		@(posedge clock) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
	) else report_mismatch("R channel changed while stalled");

	b_stalled: assert property (
		@(posedge clock) disable iff (reset) bvalid && !bready |=> bvalid && $stable(bresp)
	) else report_mismatch("B channel changed while stalled");

	// A channel that already transferred must not accept again before its response.
	ready_blocked: assert property (
		@(posedge clock) disable iff (reset)
		!(read_outstanding && arready) && !(aw_taken && awready) && !(w_taken && wready)
	) else report_mismatch("ready high while a transfer is outstanding");

	read_latency: assert property (
		@(posedge clock) disable iff (reset) read_outstanding && !rvalid |-> read_age < max_wait
	) else report_mismatch("rvalid later than the longest wait");

	write_latency: assert property (
		@(posedge clock) disable iff (reset)
		aw_taken && w_taken && !bvalid |-> write_age <= max_wait
	) else report_mismatch("bvalid later than the longest wait");

	// ************************************************************
	// Reporting and reference rules
	// ************************************************************

	task automatic report_mismatch(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped at the first failed check.");
	endtask

	task automatic give_up_waiting(input string what);
		$display("Gave up after %0d cycles waiting for %s, time %0t.", wait_limit, what, $time);
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped on a handshake timeout.");
	endtask

	function automatic logic backed_by_storage(input addr_t addr);
		return (addr >> 2) < mem_words; // Word index against the array size.
	endfunction

	function automatic data_t fill_pattern(input addr_t addr);
		return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
	endfunction

	// ************************************************************
	// Bus master
	// ************************************************************

	// Waits for rvalid or bvalid with a random ready stall each cycle.
	task automatic take_response(input logic is_read);
		int          cycles;
		logic        done;
		logic [31:0] stall;
		done = 1'b0;
		cycles = 0;
		while (!done && cycles < wait_limit) begin
			stall = $random(seed);
			rready = is_read && stall[0];
			bready = !is_read && stall[0];
			done = is_read ? (rvalid && rready) : (bvalid && bready); // Transfer at next edge.
			@(posedge clock);
			#1;
			cycles++;
		end
		rready = 1'b0;
		bready = 1'b0;
		if (!done) begin
			give_up_waiting(is_read ? "rvalid" : "bvalid");
		end
	endtask

	// Order 0 sends AW first, order 1 sends W first, order 2 sends both together.
	task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
			input int order);
		int   cycles;
		logic aw_go;
		logic w_go;
		logic aw_done;
		logic w_done;
		expected_bresp = backed_by_storage(addr) ? resp_okay : resp_slverr;
		for (int lane = 0; lane < 4; lane++) begin
			if (strb[lane] && backed_by_storage(addr)) begin
				model_mem[addr >> 2][lane*8 +: 8] = data[lane*8 +: 8]; // Byte merge.
			end
		end
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		aw_done = 1'b0;
		w_done = 1'b0;
		cycles = 0;
		while (!(aw_done && w_done) && cycles < wait_limit) begin
			awvalid = !aw_done && (order != 1 || w_done);
			wvalid = !w_done && (order != 0 || aw_done);
			aw_go = awvalid && awready;
			w_go = wvalid && wready;
			@(posedge clock);
			#1;
			aw_done = aw_done || aw_go;
			w_done = w_done || w_go;
			cycles++;
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!(aw_done && w_done)) begin
			give_up_waiting("awready and wready");
		end else begin
			take_response(1'b0);
		end
	endtask

	task automatic axi_read(input addr_t addr);
		int cycles;
		if (backed_by_storage(addr)) begin
			expected_rdata = model_mem[addr >> 2];
			expected_rresp = resp_okay;
		end else begin
			expected_rdata = '0;                  // Unbacked reads return zero.
			expected_rresp = resp_slverr;
		end
		araddr = addr;
		arvalid = 1'b1;
		cycles = 0;
		while (!arready && cycles < wait_limit) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (!arready) begin
			give_up_waiting("arready");
		end else begin
			@(posedge clock);                     // AR transfer.
			#1;
			arvalid = 1'b0;
			take_response(1'b1);
		end
	endtask

	// ************************************************************
	// Stimulus
	// ************************************************************

	initial begin
		addr_t       addr;
		data_t       data;
		logic [31:0] pick;
		reset = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		@(posedge clock);
		#1;

		// Full-strobe fill of every word, then read back.
		for (int i = 0; i < mem_words; i++) begin
			axi_write(i * 4, fill_pattern(i * 4), 4'hf, i % 3);
		end
		for (int i = 0; i < mem_words; i++) begin
			axi_read(i * 4);
		end

		// Partial strobes, one per channel order, with nonzero low address bits.
		for (int order = 0; order < 3; order++) begin
			axi_write(32'h40 + order * 5, 32'hc0de_5a00 + order,
				(order == 0) ? 4'b0101 : (order == 1) ? 4'b1010 : 4'b0110, order);
			axi_read(32'h40 + order * 4);
		end

		// Unbacked addresses, then the word they would alias onto.
		axi_write(mem_words * 4 + 8, 32'hdead_beef, 4'hf, 2);
		axi_read(mem_words * 4 + 8);
		axi_read(8);
		axi_write(32'hffff_fffc, 32'h1234_5678, 4'hf, 0);
		axi_read(32'hffff_fffc);

		// Random mix, a few addresses past the end.
		for (int round = 0; round < 200; round++) begin
			pick = $random(seed);
			addr = pick % ((mem_words + 4) * 4);
			data = $random(seed);
			axi_write(addr, data, pick[31:28], pick[27:26] % 3);
			pick = $random(seed);
			axi_read(pick % (mem_words * 4));
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
source/sram_pkg.sv
source/lfsr_random.sv
source/response_delay.sv
source/sram_array.sv
source/axi_lite_sram.sv
source/sram_subsystem.sv
sim/tb_sram_subsystem.sv
